//--- rtl/ctrlPkg.sv
package ctrlPkg;

  // Primary opcode field in instr[31:26]
  typedef enum logic [5:0] {
    opcRType = 6'b000000,
    opcJ     = 6'b000010,
    opcJal   = 6'b000011,
    opcAddi  = 6'b001000,
    opcAddiu = 6'b001001,
    opcSlti  = 6'b001010,
    opcLui   = 6'b001111,
    opcSw    = 6'b101011
  } opcode_e;

  // R-type function field in instr[5:0]
  typedef enum logic [5:0] {
    fnXchg = 6'b000101,
    fnJr   = 6'b001000,
    fnMfhi = 6'b010000,
    fnMflo = 6'b010010,
    fnAdd  = 6'b100000,
    fnSub  = 6'b100010,
    fnAnd  = 6'b100100,
    fnSlt  = 6'b101010
  } funct_e;

  typedef enum logic [3:0] {
    opAdd,
    opSub,
    opAnd,
    opSlt,
    opAddi,
    opAddiu,
    opSlti,
    opLui,
    opSw,
    opJ,
    opJal,
    opJr,
    opMfhi,
    opMflo,
    opXchg,
    opInvalid
  } operation_e;

  typedef enum logic [3:0] {
    stIdle,
    stFetchWait,
    stFetchPc,
    stFetchIr,
    stDecode,
    stExecute,
    stExecute2,
    stExcOverflow,
    stExcOpcode
  } state_e;

  // Encodings follow the datapath ALU selector
  typedef enum logic [2:0] {
    aluPass = 3'b000,
    aluAdd  = 3'b001,
    aluSub  = 3'b010,
    aluAnd  = 3'b011,
    aluSlt  = 3'b111
  } aluOp_e;

  typedef enum logic {
    srcAPc,
    srcARegA
  } aluSrcA_e;

  typedef enum logic [1:0] {
    srcBRegB,
    srcBFour,
    srcBImm
  } aluSrcB_e;

  typedef enum logic [1:0] {
    dstRt,
    dstRd,
    dstRa,
    dstRs
  } regDst_e;

  typedef enum logic [2:0] {
    wbAluOut,
    wbHi,
    wbLo,
    wbUpperImm,
    wbPc,
    wbRegA,
    wbRegB
  } memToReg_e;

  // Memory address select with both exception vectors
  typedef enum logic [1:0] {
    addrPc,
    addrAluResult,
    addrVecOverflow,
    addrVecOpcode
  } iorD_e;

  typedef enum logic {
    pcAluResult,
    pcJumpTarget
  } pcSource_e;

  typedef struct packed {
    logic       pcWrite;
    logic       aWrite;
    logic       bWrite;
    logic       epcWrite;
    logic       irWrite;
    logic       regWrite;
    logic       memWrite;
    aluOp_e     aluOp;
    aluSrcA_e   aluSrcA;
    aluSrcB_e   aluSrcB;
    regDst_e    regDst;
    memToReg_e  memToReg;
    iorD_e      iorD;
    pcSource_e  pcSource;
  } ctrlWord_t;

  typedef struct packed {
    state_e     state;
    operation_e op;
  } seqStatus_t;

endpackage

//--- rtl/instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder (
  input  ctrlPkg::opcode_e    opcode,
  input  ctrlPkg::funct_e     funct,
  output ctrlPkg::operation_e op
);
  import ctrlPkg::*;

  operation_e rTypeOp;

  // R-type selects on funct only
  always_comb begin
    case (funct)
      fnAdd:   rTypeOp = opAdd;
      fnSub:   rTypeOp = opSub;
      fnAnd:   rTypeOp = opAnd;
      fnSlt:   rTypeOp = opSlt;
      fnJr:    rTypeOp = opJr;
      fnMfhi:  rTypeOp = opMfhi;
      fnMflo:  rTypeOp = opMflo;
      fnXchg:  rTypeOp = opXchg;
      default: rTypeOp = opInvalid;
    endcase
  end

  always_comb begin
    case (opcode)
      opcRType: op = rTypeOp;
      opcAddi:  op = opAddi;
      opcAddiu: op = opAddiu;
      opcSlti:  op = opSlti;
      opcLui:   op = opLui;
      opcSw:    op = opSw;
      opcJ:     op = opJ;
      opcJal:   op = opJal;
      // Anything else raises the opcode exception
      default:  op = opInvalid;
    endcase
  end

endmodule

//--- rtl/cycleSequencer.sv
`timescale 1ns/100ps

module cycleSequencer #(
  parameter int MemWaitCycles = 2
) (
  input  logic                clk,
  input  logic                reset,
  input  ctrlPkg::operation_e op,
  input  logic                overflow,
  output ctrlPkg::seqStatus_t status
);
  import ctrlPkg::*;

  localparam int WaitWidth = (MemWaitCycles > 1) ? $clog2(MemWaitCycles) : 1;

  state_e               state;
  state_e               nextState;
  operation_e           opReg;
  logic [WaitWidth-1:0] waitCount;
  logic                 waitDone;
  logic                 trapsOverflow;

  assign waitDone = (waitCount == WaitWidth'(MemWaitCycles - 1));

  // Only signed adds and subtracts trap
  assign trapsOverflow = (opReg == opAdd) || (opReg == opSub) || (opReg == opAddi);

  always_comb begin
    nextState = state;
    case (state)
      stIdle:      nextState = stFetchWait;
      stFetchWait: nextState = waitDone ? stFetchPc : stFetchWait;
      stFetchPc:   nextState = stFetchIr;
      stFetchIr:   nextState = stDecode;
      // Decoder output used directly as opReg loads on this same edge
      stDecode:    nextState = (op == opInvalid) ? stExcOpcode : stExecute;
      stExecute: begin
        if (opReg == opXchg) begin
          nextState = stExecute2;
        end else if (overflow && trapsOverflow) begin
          nextState = stExcOverflow;
        end else begin
          nextState = stFetchWait;
        end
      end
      default:     nextState = stFetchWait;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stIdle;
    end else begin
      state <= nextState;
    end
  end

  // Counts memory wait cycles and clears outside fetch wait
  always_ff @(posedge clk) begin
    if (reset) begin
      waitCount <= '0;
    end else if (state == stFetchWait && !waitDone) begin
      waitCount <= waitCount + 1'b1;
    end else begin
      waitCount <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      opReg <= opInvalid;
    end else if (state == stDecode) begin
      opReg <= op;
    end
  end

  assign status = '{state: state, op: opReg};

endmodule

//--- rtl/controlWordGen.sv
`timescale 1ns/100ps

module controlWordGen (
  input  ctrlPkg::seqStatus_t status,
  output ctrlPkg::ctrlWord_t  ctrl
);
  import ctrlPkg::*;

  always_comb begin
    ctrl = '0;
    case (status.state)
      stFetchWait: ctrl.iorD = addrPc;
      // PC + 4 while memory returns the instruction
      stFetchPc: begin
        ctrl.pcWrite  = 1'b1;
        ctrl.aluOp    = aluAdd;
        ctrl.aluSrcA  = srcAPc;
        ctrl.aluSrcB  = srcBFour;
        ctrl.pcSource = pcAluResult;
        ctrl.iorD     = addrPc;
      end
      stFetchIr: ctrl.irWrite = 1'b1;
      stDecode: begin
        ctrl.aWrite = 1'b1;
        ctrl.bWrite = 1'b1;
      end
      stExecute: begin
        case (status.op)
          opAdd, opSub, opAnd, opSlt: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluSrcA  = srcARegA;
            ctrl.aluSrcB  = srcBRegB;
            ctrl.regDst   = dstRd;
            ctrl.memToReg = wbAluOut;
            case (status.op)
              opSub:   ctrl.aluOp = aluSub;
              opAnd:   ctrl.aluOp = aluAnd;
              opSlt:   ctrl.aluOp = aluSlt;
              default: ctrl.aluOp = aluAdd;
            endcase
          end
          opAddi, opAddiu, opSlti: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = (status.op == opSlti) ? aluSlt : aluAdd;
            ctrl.aluSrcA  = srcARegA;
            ctrl.aluSrcB  = srcBImm;
            ctrl.regDst   = dstRt;
            ctrl.memToReg = wbAluOut;
          end
          opLui: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = dstRt;
            ctrl.memToReg = wbUpperImm;
          end
          // Store address is rs + imm
          opSw: begin
            ctrl.memWrite = 1'b1;
            ctrl.aluOp    = aluAdd;
            ctrl.aluSrcA  = srcARegA;
            ctrl.aluSrcB  = srcBImm;
            ctrl.iorD     = addrAluResult;
          end
          opJ, opJal: begin
            ctrl.pcWrite  = 1'b1;
            ctrl.pcSource = pcJumpTarget;
            if (status.op == opJal) begin
              ctrl.regWrite = 1'b1;
              ctrl.regDst   = dstRa;
              ctrl.memToReg = wbPc;
            end
          end
          opJr: begin
            ctrl.pcWrite  = 1'b1;
            ctrl.aluOp    = aluPass;
            ctrl.aluSrcA  = srcARegA;
            ctrl.pcSource = pcAluResult;
          end
          opMfhi, opMflo: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = dstRd;
            ctrl.memToReg = (status.op == opMfhi) ? wbHi : wbLo;
          end
          // First half of the swap writes old rt into rs
          opXchg: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = dstRs;
            ctrl.memToReg = wbRegB;
          end
          default: ctrl = '0;
        endcase
      end
      stExecute2: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = dstRt;
        ctrl.memToReg = wbRegA;
      end
      stExcOverflow: begin
        ctrl.epcWrite = 1'b1;
        ctrl.iorD     = addrVecOverflow;
      end
      stExcOpcode: begin
        ctrl.epcWrite = 1'b1;
        ctrl.iorD     = addrVecOpcode;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

//--- rtl/controlUnit.sv
`timescale 1ns/100ps

module controlUnit #(
  parameter int MemWaitCycles = 2
) (
  input  logic               clk,
  input  logic               reset,
  input  ctrlPkg::opcode_e   opcode,
  input  ctrlPkg::funct_e    funct,
  input  logic               overflow,
  output ctrlPkg::ctrlWord_t ctrl
);
  import ctrlPkg::*;

  operation_e op;
  seqStatus_t status;

  instrDecoder u_instrDecoder (
    .opcode (opcode),
    .funct  (funct),
    .op     (op)
  );

  cycleSequencer #(
    .MemWaitCycles (MemWaitCycles)
  ) u_cycleSequencer (
    .clk      (clk),
    .reset    (reset),
    .op       (op),
    .overflow (overflow),
    .status   (status)
  );

  controlWordGen u_controlWordGen (
    .status (status),
    .ctrl   (ctrl)
  );

endmodule

//--- bench/controlUnit_sva.sv
`timescale 1ns/100ps

module controlUnit_sva (
  input logic               clk,
  input logic               reset,
  input ctrlPkg::ctrlWord_t ctrl
);

  // Sequencer sits in idle after every reset edge
  resetZero: assert property (@(posedge clk) reset |=> ctrl == '0)
    else $error("ctrl is not zero while reset is held");

  irThenDecode: assert property (
    @(posedge clk) disable iff (reset)
    ctrl.irWrite |=> ctrl.aWrite
  ) else $error("irWrite was not followed by aWrite");

  noMemAndReg: assert property (
    @(posedge clk) disable iff (reset)
    !(ctrl.memWrite && ctrl.regWrite)
  ) else $error("memWrite and regWrite high together");

  // Exception states last one cycle
  singleEpc: assert property (
    @(posedge clk) disable iff (reset)
    ctrl.epcWrite |=> !ctrl.epcWrite
  ) else $error("epcWrite high two cycles in a row");

endmodule

bind controlUnit controlUnit_sva u_controlUnitSva (
  .clk   (clk),
  .reset (reset),
  .ctrl  (ctrl)
);

//--- bench/controlUnitTb.sv
`timescale 1ns/100ps

module controlUnitTb;
  import ctrlPkg::*;

  localparam int Period     = 100;
  localparam int WaitCycles = 2;
  localparam int Rows       = 23;
  localparam int RandomRows = 8;
  localparam int CycleLimit = (Rows + RandomRows) * 8 + 20;

  // Instruction class a row is expected to decode to
  typedef enum logic [3:0] {
    kAdd, kSub, kAnd, kSlt, kAddi, kAddiu, kSlti, kLui,
    kSw, kJ, kJal, kJr, kMfhi, kMflo, kXchg, kInvalid
  } kind_e;

  typedef struct packed {
    logic [5:0] opc;
    logic [5:0] fn;
    logic       ovf;
    kind_e      kind;
  } stim_t;

  logic      clk;
  logic      reset;
  opcode_e   opcode;
  funct_e    funct;
  logic      overflow;
  ctrlWord_t ctrl;

  int errorCount = 0;
  int checkCount = 0;
  int cycleCount = 0;

  string rowName [Rows] = '{
    "add", "sub", "and", "slt", "addi", "addiu", "slti", "lui",
    "sw", "j", "jal", "jr", "mfhi", "mflo", "xchg",
    "add overflow", "sub overflow", "addi overflow", "addiu overflow",
    "opcode 3f", "funct 01", "opcode 04", "funct 18"
  };

  stim_t rowStim [Rows] = '{
    '{opcRType, fnAdd, 1'b0, kAdd},
    '{opcRType, fnSub, 1'b0, kSub},
    '{opcRType, fnAnd, 1'b0, kAnd},
    '{opcRType, fnSlt, 1'b0, kSlt},
    '{opcAddi, fnAdd, 1'b0, kAddi},
    '{opcAddiu, fnAdd, 1'b0, kAddiu},
    '{opcSlti, fnAdd, 1'b0, kSlti},
    '{opcLui, fnAdd, 1'b0, kLui},
    '{opcSw, fnAdd, 1'b0, kSw},
    '{opcJ, fnAdd, 1'b0, kJ},
    '{opcJal, fnAdd, 1'b0, kJal},
    '{opcRType, fnJr, 1'b0, kJr},
    '{opcRType, fnMfhi, 1'b0, kMfhi},
    '{opcRType, fnMflo, 1'b0, kMflo},
    '{opcRType, fnXchg, 1'b0, kXchg},
    '{opcRType, fnAdd, 1'b1, kAdd},
    '{opcRType, fnSub, 1'b1, kSub},
    '{opcAddi, fnAdd, 1'b1, kAddi},
    '{opcAddiu, fnAdd, 1'b1, kAddiu},
    '{6'h3F, fnAdd, 1'b0, kInvalid},
    '{opcRType, 6'h01, 1'b0, kInvalid},
    '{6'h04, fnAdd, 1'b0, kInvalid},
    '{opcRType, 6'h18, 1'b0, kInvalid}
  };

  controlUnit #(
    .MemWaitCycles (WaitCycles)
  ) u_controlUnit (
    .clk      (clk),
    .reset    (reset),
    .opcode   (opcode),
    .funct    (funct),
    .overflow (overflow),
    .ctrl     (ctrl)
  );

  initial clk = 1'b0;
  always #(Period / 2) clk = ~clk;

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("Errors found");
      $finish;
    end
  end

  function automatic int unsigned lcgNext(int unsigned seed);
    return seed * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic isKeptOpcode(logic [5:0] opc);
    case (opc)
      opcRType, opcJ, opcJal, opcAddi, opcAddiu, opcSlti, opcLui, opcSw: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic int instrCycles(kind_e kind, logic ovf);
    if (kind == kXchg || (ovf && (kind == kAdd || kind == kSub || kind == kAddi))) begin
      return WaitCycles + 5;
    end
    return WaitCycles + 4;
  endfunction

  // Single execute word or the first one for xchg
  function automatic ctrlWord_t execWord(kind_e kind);
    ctrlWord_t w;
    w = '0;
    case (kind)
      kAdd, kSub, kAnd, kSlt: begin
        w.regWrite = 1'b1;
        w.aluSrcA  = srcARegA;
        w.aluSrcB  = srcBRegB;
        w.regDst   = dstRd;
        w.memToReg = wbAluOut;
        w.aluOp    = (kind == kAdd) ? aluAdd : (kind == kSub) ? aluSub :
                     (kind == kAnd) ? aluAnd : aluSlt;
      end
      kAddi, kAddiu, kSlti: begin
        w.regWrite = 1'b1;
        w.aluOp    = (kind == kSlti) ? aluSlt : aluAdd;
        w.aluSrcA  = srcARegA;
        w.aluSrcB  = srcBImm;
        w.regDst   = dstRt;
      end
      kLui: begin
        w.regWrite = 1'b1;
        w.regDst   = dstRt;
        w.memToReg = wbUpperImm;
      end
      kSw: begin
        w.memWrite = 1'b1;
        w.aluOp    = aluAdd;
        w.aluSrcA  = srcARegA;
        w.aluSrcB  = srcBImm;
        w.iorD     = addrAluResult;
      end
      kJ, kJal: begin
        w.pcWrite  = 1'b1;
        w.pcSource = pcJumpTarget;
        w.regWrite = (kind == kJal);
        w.regDst   = (kind == kJal) ? dstRa : dstRt;
        w.memToReg = (kind == kJal) ? wbPc : wbAluOut;
      end
      kJr: begin
        w.pcWrite = 1'b1;
        w.aluOp   = aluPass;
        w.aluSrcA = srcARegA;
      end
      kMfhi, kMflo: begin
        w.regWrite = 1'b1;
        w.regDst   = dstRd;
        w.memToReg = (kind == kMfhi) ? wbHi : wbLo;
      end
      kXchg: begin
        w.regWrite = 1'b1;
        w.regDst   = dstRs;
        w.memToReg = wbRegB;
      end
      default: w = '0;
    endcase
    return w;
  endfunction

  // Expected word for one cycle of an instruction where step 0 is the first wait cycle
  function automatic ctrlWord_t refWord(kind_e kind, int step);
    ctrlWord_t w;
    w = '0;
    if (step < WaitCycles) begin
      w.iorD = addrPc;
    end else if (step == WaitCycles) begin
      w.pcWrite = 1'b1;
      w.aluOp   = aluAdd;
      w.aluSrcA = srcAPc;
      w.aluSrcB = srcBFour;
      w.iorD    = addrPc;
    end else if (step == WaitCycles + 1) begin
      w.irWrite = 1'b1;
    end else if (step == WaitCycles + 2) begin
      w.aWrite = 1'b1;
      w.bWrite = 1'b1;
    end else if (step == WaitCycles + 3 && kind == kInvalid) begin
      w.epcWrite = 1'b1;
      w.iorD     = addrVecOpcode;
    end else if (step == WaitCycles + 3) begin
      w = execWord(kind);
    end else if (kind == kXchg) begin
      w.regWrite = 1'b1;
      w.regDst   = dstRt;
      w.memToReg = wbRegA;
    end else begin
      w.epcWrite = 1'b1;
      w.iorD     = addrVecOverflow;
    end
    return w;
  endfunction

  task automatic checkCtrl(string name, ctrlWord_t expected, ctrlWord_t actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic runInstr(string name, stim_t stim);
    int cycles;
    cycles = instrCycles(stim.kind, stim.ovf);
    for (int step = 0; step < cycles; step++) begin
      @(posedge clk);
      #1;
      if (step == 0) begin
        opcode   = opcode_e'(stim.opc);
        funct    = funct_e'(stim.fn);
        overflow = stim.ovf;
      end
      #(Period - 2);
      checkCtrl($sformatf("%s step %0d", name, step), refWord(stim.kind, step), ctrl);
    end
  endtask

  initial begin
    int unsigned seed;
    int          found;
    stim_t       randStim;
    reset    = 1'b1;
    opcode   = opcRType;
    funct    = fnAdd;
    overflow = 1'b0;
    seed     = 48061;
    found    = 0;
    // Idle cycle after release is checked too
    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
      #1;
      if (i == 4) begin
        reset = 1'b0;
      end
      #(Period - 2);
      checkCtrl("reset", '0, ctrl);
    end
    for (int r = 0; r < Rows; r++) begin
      runInstr(rowName[r], rowStim[r]);
    end
    while (found < RandomRows) begin
      seed = lcgNext(seed);
      randStim.opc  = 6'(seed >> 16);
      randStim.fn   = fnAdd;
      randStim.ovf  = 1'b0;
      randStim.kind = kInvalid;
      if (!isKeptOpcode(randStim.opc)) begin
        runInstr($sformatf("random opcode %h", randStim.opc), randStim);
        found++;
      end
    end
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- src.f
rtl/ctrlPkg.sv
rtl/instrDecoder.sv
rtl/cycleSequencer.sv
rtl/controlWordGen.sv
rtl/controlUnit.sv
bench/controlUnit_sva.sv
bench/controlUnitTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module controlUnitTb \
  -Mdir obj_dir -o controlUnitSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/controlUnitSim)
simStatus=$?
printf '%s\n' "$output"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
  exit 0
fi
exit 1
